/* verilog/wb_pkg.sv */
package wb_pkg;

    // Register file geometry
    localparam int reg_sel_w = 5;   // 32 architectural registers
    localparam int word_w    = 32;  // Data path width

    typedef logic [reg_sel_w-1:0] reg_sel_t;

    // One register file write
    // valid is the done strobe at the inputs
    // At a queue head it means the entry may be written now
    typedef struct packed {
        logic              valid;
        reg_sel_t          reg_sel;  // Destination register
        logic [word_w-1:0] wdat;     // Write data
    } wb_t;

    // Speculation window tracking
    typedef enum logic {
        IDLE = 1'b0,  // No branch outstanding
        SPEC = 1'b1   // Branch unresolved, ALU results held back
    } spec_state_t;

    // Source that owns the current writeback
    typedef enum logic [1:0] {
        NONE = 2'd0,  // No write this cycle
        JUMP = 2'd1,  // Link value from jump unit
        ALU  = 2'd2,  // Head of ALU queue
        LOAD = 2'd3   // Head of load queue
    } wb_src_t;

endpackage

/* verilog/wb_intake.sv */
`timescale 1ns/10ps

module wb_intake (
    input  logic          CLK,
    input  logic          nRST,
    input  wb_pkg::wb_t   alu_in,
    input  wb_pkg::wb_t   load_in,
    input  wb_pkg::wb_t   jump_in,
    input  logic          branch_spec,        // Level, high while branch unresolved
    input  logic          branch_correct,     // One cycle pulse
    input  logic          branch_mispredict,  // One cycle pulse
    output wb_pkg::wb_t   alu_q,
    output wb_pkg::wb_t   load_q,
    output wb_pkg::wb_t   jump_q,
    output logic          alu_spec,           // alu_q belongs to the open window
    output logic          commit,             // Spec entries become ordinary
    output logic          squash              // Spec entries are dropped
);

    wb_pkg::spec_state_t state, state_n;
    logic prev_spec;   // branch_spec one cycle ago
    logic spec_rise;
    logic outcome;
    logic in_window;

    assign spec_rise = branch_spec && !prev_spec;
    assign outcome   = branch_correct || branch_mispredict;

    // Outcome in the same cycle the window opens still counts
    assign in_window = (state == wb_pkg::SPEC) || spec_rise;

    // Speculation window FSM
    always_comb begin
        state_n = state;
        case (state)
            wb_pkg::IDLE: begin
                if (spec_rise && !outcome) begin
                    state_n = wb_pkg::SPEC;   // Window opens
                end
            end
            wb_pkg::SPEC: begin
                if (outcome) begin
                    state_n = wb_pkg::IDLE;   // Branch resolved either way
                end
            end
            default: state_n = wb_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= wb_pkg::IDLE;
            prev_spec <= 1'b0;
            alu_q     <= '0;
            load_q    <= '0;
            jump_q    <= '0;
            alu_spec  <= 1'b0;
            commit    <= 1'b0;
            squash    <= 1'b0;
        end else begin
            state     <= state_n;
            prev_spec <= branch_spec;
            alu_q     <= alu_in;
            load_q    <= load_in;
            jump_q    <= jump_in;       // Straight on to the arbiter
            alu_spec  <= alu_in.valid && branch_spec;
            // Outcome pulses delayed to line up with registered results
            commit    <= branch_correct && in_window;
            squash    <= branch_mispredict && in_window;
        end
    end

endmodule

/* verilog/wb_alu_queue.sv */
`timescale 1ns/10ps

module wb_alu_queue #(
    parameter int BUFFER_DEPTH = 4   // Power of two
) (
    input  logic          CLK,
    input  logic          nRST,
    input  wb_pkg::wb_t   push,
    input  logic          push_spec,  // Pushed entry is speculative
    input  logic          commit,
    input  logic          squash,
    input  logic          pop,
    output wb_pkg::wb_t   head,       // valid only for a non-speculative head
    output logic          ready
);

    localparam int ptr_w = $clog2(BUFFER_DEPTH);
    localparam int cnt_w = $clog2(BUFFER_DEPTH + 1);

    wb_pkg::wb_t             mem [BUFFER_DEPTH];
    logic [BUFFER_DEPTH-1:0] spec_bits;      // One per slot
    logic [ptr_w-1:0]        wptr, rptr;
    logic [ptr_w-1:0]        saved_wptr;     // Slot of first spec entry
    logic [cnt_w-1:0]        count;          // Occupancy incl. spec entries
    logic [cnt_w-1:0]        spec_cnt;       // Spec entries in flight

    logic                    wr_en;
    logic                    wr_spec;
    logic                    rd_en;
    logic [ptr_w-1:0]        wr_addr;
    logic [ptr_w-1:0]        wptr_n;
    logic [cnt_w-1:0]        count_n;
    logic [cnt_w-1:0]        spec_cnt_n;

    // Head presentation
    always_comb begin
        head       = mem[rptr];
        head.valid = (count != '0) && !spec_bits[rptr];  // Spec head waits
    end

    // Room for the result still in the intake register
    assign ready = (count < cnt_w'(BUFFER_DEPTH - 1));

    assign rd_en = pop && head.valid;

    // Next pointer and counters
    always_comb begin
        wr_en      = push.valid;
        wr_spec    = push.valid && push_spec;
        wr_addr    = wptr;
        wptr_n     = wptr + ptr_w'(wr_en);   // Wraps naturally
        spec_cnt_n = spec_cnt + cnt_w'(wr_spec);
        count_n    = count + cnt_w'(wr_en) - cnt_w'(rd_en);
        if (squash) begin
            // Rewind to first spec slot, stay put if the window pushed nothing
            wr_en      = push.valid && !push_spec;  // Late spec push dropped too
            wr_addr    = (spec_cnt != '0) ? saved_wptr : wptr;
            wptr_n     = wr_addr + ptr_w'(wr_en);
            spec_cnt_n = '0;
            count_n    = count - spec_cnt + cnt_w'(wr_en) - cnt_w'(rd_en);
        end else if (commit) begin
            spec_cnt_n = '0;   // Everything ordinary from here
        end
    end

    // Control state
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr       <= '0;
            rptr       <= '0;
            saved_wptr <= '0;
            count      <= '0;
            spec_cnt   <= '0;
            spec_bits  <= '0;
        end else begin
            wptr     <= wptr_n;
            count    <= count_n;
            spec_cnt <= spec_cnt_n;
            if (rd_en) begin
                rptr <= rptr + ptr_w'(1);
            end
            // Remember where the window started
            if (wr_spec && !squash && !commit && (spec_cnt == '0)) begin
                saved_wptr <= wptr;
            end
            if (commit) begin
                spec_bits <= '0;
            end
            if (wr_en) begin
                spec_bits[wr_addr] <= wr_spec && !commit && !squash;
            end
        end
    end

    // Payload storage
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_addr] <= push;
        end
    end

endmodule

/* verilog/wb_load_queue.sv */
`timescale 1ns/10ps

module wb_load_queue #(
    parameter int BUFFER_DEPTH = 4   // Power of two
) (
    input  logic          CLK,
    input  logic          nRST,
    input  wb_pkg::wb_t   push,
    input  logic          pop,
    output wb_pkg::wb_t   head,
    output logic          ready
);

    localparam int ptr_w = $clog2(BUFFER_DEPTH);
    localparam int cnt_w = $clog2(BUFFER_DEPTH + 1);

    wb_pkg::wb_t      mem [BUFFER_DEPTH];
    logic [ptr_w-1:0] wptr, rptr;
    logic [cnt_w-1:0] count;
    logic             rd_en;

    always_comb begin
        head       = mem[rptr];
        head.valid = (count != '0);   // Loads never speculative
    end

    assign ready = (count < cnt_w'(BUFFER_DEPTH - 1));  // One slot kept for in-flight result
    assign rd_en = pop && head.valid;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push.valid) begin
                wptr <= wptr + ptr_w'(1);
            end
            if (rd_en) begin
                rptr <= rptr + ptr_w'(1);
            end
            count <= count + cnt_w'(push.valid) - cnt_w'(rd_en);
        end
    end

    // Payload storage
    always_ff @(posedge CLK) begin
        if (push.valid) begin
            mem[wptr] <= push;
        end
    end

endmodule

/* verilog/wb_arbiter.sv */
`timescale 1ns/10ps

module wb_arbiter (
    input  logic              CLK,
    input  logic              nRST,
    input  wb_pkg::wb_t       jump_q,
    input  wb_pkg::wb_t       alu_head,
    input  wb_pkg::wb_t       load_head,
    output logic              alu_pop,
    output logic              load_pop,
    output wb_pkg::wb_t       wb_out,   // Registered register file write
    output wb_pkg::wb_src_t   wb_src
);

    logic            rr_alu;     // High when ALU wins the next contest
    logic            rr_alu_n;
    wb_pkg::wb_t     win;
    wb_pkg::wb_src_t win_src;

    // Selection
    always_comb begin
        alu_pop  = 1'b0;
        load_pop = 1'b0;
        rr_alu_n = rr_alu;
        win      = '0;
        win_src  = wb_pkg::NONE;
        if (jump_q.valid) begin
            // Jump bypasses the queues, heads wait
            win     = jump_q;
            win_src = wb_pkg::JUMP;
        end else if (alu_head.valid && load_head.valid) begin
            rr_alu_n = !rr_alu;   // Toggle only when contested
            if (rr_alu) begin
                win     = alu_head;
                win_src = wb_pkg::ALU;
                alu_pop = 1'b1;
            end else begin
                win      = load_head;
                win_src  = wb_pkg::LOAD;
                load_pop = 1'b1;
            end
        end else if (alu_head.valid) begin
            win     = alu_head;
            win_src = wb_pkg::ALU;
            alu_pop = 1'b1;
        end else if (load_head.valid) begin
            win      = load_head;
            win_src  = wb_pkg::LOAD;
            load_pop = 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rr_alu <= 1'b0;          // LOAD takes the first contest
            wb_out <= '0;
            wb_src <= wb_pkg::NONE;
        end else begin
            rr_alu <= rr_alu_n;
            wb_out <= win;
            wb_src <= win_src;
        end
    end

endmodule

/* verilog/writeback_top.sv */
`timescale 1ns/10ps

module writeback_top #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic              CLK,
    input  logic              nRST,
    input  wb_pkg::wb_t       alu_in,
    input  wb_pkg::wb_t       load_in,
    input  wb_pkg::wb_t       jump_in,
    input  logic              branch_spec,
    input  logic              branch_correct,
    input  logic              branch_mispredict,
    output wb_pkg::wb_t       wb_out,
    output wb_pkg::wb_src_t   wb_src,
    output logic              alu_ready,
    output logic              load_ready
);

    // Stage 1 to stage 2
    wb_pkg::wb_t alu_q, load_q, jump_q;
    logic        alu_spec;
    logic        commit;
    logic        squash;

    // Stage 2 to stage 3 and back
    wb_pkg::wb_t alu_head, load_head;
    logic        alu_pop, load_pop;

    wb_intake u_intake (
        .CLK               (CLK),
        .nRST              (nRST),
        .alu_in            (alu_in),
        .load_in           (load_in),
        .jump_in           (jump_in),
        .branch_spec       (branch_spec),
        .branch_correct    (branch_correct),
        .branch_mispredict (branch_mispredict),
        .alu_q             (alu_q),
        .load_q            (load_q),
        .jump_q            (jump_q),
        .alu_spec          (alu_spec),
        .commit            (commit),
        .squash            (squash)
    );

    wb_alu_queue #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_alu_queue (
        .CLK       (CLK),
        .nRST      (nRST),
        .push      (alu_q),
        .push_spec (alu_spec),
        .commit    (commit),
        .squash    (squash),
        .pop       (alu_pop),
        .head      (alu_head),
        .ready     (alu_ready)
    );

    wb_load_queue #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_load_queue (
        .CLK   (CLK),
        .nRST  (nRST),
        .push  (load_q),
        .pop   (load_pop),
        .head  (load_head),
        .ready (load_ready)
    );

    wb_arbiter u_arbiter (
        .CLK       (CLK),
        .nRST      (nRST),
        .jump_q    (jump_q),    // Jump skips the queues
        .alu_head  (alu_head),
        .load_head (load_head),
        .alu_pop   (alu_pop),
        .load_pop  (load_pop),
        .wb_out    (wb_out),
        .wb_src    (wb_src)
    );

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD       = 100,  // ns
    parameter int RESET_CYCLES = 8
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // Release reset just after a rising edge, in step with the drivers
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #10;
        nRST = 1'b1;
    end

endmodule

/* tb/tb_checker.sv */
`timescale 1ns/10ps

module tb_checker #(
    parameter int BUFFER_DEPTH = 4
) (
    input  logic              CLK,
    input  logic              nRST,
    input  wb_pkg::wb_t       alu_in,
    input  wb_pkg::wb_t       load_in,
    input  wb_pkg::wb_t       jump_in,
    input  logic              branch_spec,
    input  logic              branch_correct,
    input  logic              branch_mispredict,
    input  wb_pkg::wb_t       wb_out,
    input  wb_pkg::wb_src_t   wb_src,
    input  logic              alu_ready,
    input  logic              load_ready,
    input  logic              count_clr,  // Start of a new test
    output int                errors,
    output int                n_alu,      // Writes seen in the current test
    output int                n_load,
    output int                n_jump,
    output logic              busy        // Expected writes still outstanding
);

    localparam int never = 32'h7fffffff;  // Speculative, not yet eligible

    // Inputs seen at one edge
    typedef struct packed {
        logic alu;
        logic load;
        logic spec;
        logic correct;
        logic mispredict;
    } smp_t;

    wb_pkg::wb_t alu_exp[$];
    int          alu_elig[$];    // First edge the entry may be written
    bit          alu_mark[$];    // Taken while branch_spec was high
    wb_pkg::wb_t load_exp[$];
    int          load_elig[$];
    wb_pkg::wb_t jump_exp[$];
    int          jump_at[$];     // Sample edge of the jump
    int          cyc;            // Edge counter since reset
    int          n_in;           // Expected writes recorded
    int          n_out;          // Expected writes consumed
    bit          rr_alu;         // Model of the round-robin bit
    smp_t        smp_now;        // Sampled at the latest edge
    smp_t        smp_prev;       // One edge earlier, reaching the queues now
    int          alu_occ;        // Model of ALU queue occupancy
    int          alu_spec_occ;   // Speculative part of it
    int          load_occ;

    assign busy = (n_in != n_out);

    // Record issued results at the edge the DUT samples them
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            alu_exp.delete();
            alu_elig.delete();
            alu_mark.delete();
            load_exp.delete();
            load_elig.delete();
            jump_exp.delete();
            jump_at.delete();
            cyc      = 0;
            n_in     = 0;
            smp_now  = '0;
            smp_prev = '0;
        end else begin
            cyc++;
            smp_prev = smp_now;
            smp_now  = {alu_in.valid, load_in.valid, branch_spec,
                        branch_correct, branch_mispredict};
            if (alu_in.valid) begin
                alu_exp.push_back(alu_in);
                alu_elig.push_back(branch_spec ? never : cyc + 2);  // Intake plus queue
                alu_mark.push_back(branch_spec);
                n_in++;
            end
            if (load_in.valid) begin
                load_exp.push_back(load_in);
                load_elig.push_back(cyc + 2);
                n_in++;
            end
            if (jump_in.valid) begin
                jump_exp.push_back(jump_in);
                jump_at.push_back(cyc);
                n_in++;
            end
            if (branch_correct) begin
                foreach (alu_mark[i]) begin
                    if (alu_mark[i]) begin
                        alu_mark[i] = 1'b0;
                        alu_elig[i] = cyc + 2;   // Commit lands one edge later
                    end
                end
            end
            if (branch_mispredict) begin
                for (int i = alu_mark.size() - 1; i >= 0; i--) begin
                    if (alu_mark[i]) begin
                        alu_exp.delete(i);
                        alu_elig.delete(i);
                        alu_mark.delete(i);
                        n_in--;   // Never written
                    end
                end
            end
        end
    end

    // Compare the registered output half a cycle after it changes
    always @(negedge CLK or negedge nRST) begin
        wb_pkg::wb_src_t exp_src;
        wb_pkg::wb_t     exp_val;
        bit              alu_ok;
        bit              load_ok;
        if (!nRST) begin
            errors       = 0;
            n_out        = 0;
            n_alu        = 0;
            n_load       = 0;
            n_jump       = 0;
            rr_alu       = 1'b0;   // LOAD takes the first contest
            alu_occ      = 0;
            alu_spec_occ = 0;
            load_occ     = 0;
        end else begin
            if (count_clr) begin
                n_alu  = 0;
                n_load = 0;
                n_jump = 0;
            end
            exp_src = wb_pkg::NONE;
            exp_val = '0;
            alu_ok  = (alu_exp.size() != 0) && (alu_elig[0] <= cyc);
            load_ok = (load_exp.size() != 0) && (load_elig[0] <= cyc);
            if (jump_exp.size() != 0 && jump_at[0] + 1 < cyc) begin
                $display("Jump to r%0d was not written one edge after it was sampled",
                         jump_exp[0].reg_sel);
                errors++;
                void'(jump_exp.pop_front());
                void'(jump_at.pop_front());
                n_out++;
            end
            if (jump_exp.size() != 0 && jump_at[0] + 1 == cyc) begin
                exp_src = wb_pkg::JUMP;   // Queues wait behind a jump
            end else if (alu_ok && load_ok) begin
                exp_src = rr_alu ? wb_pkg::ALU : wb_pkg::LOAD;
                rr_alu  = !rr_alu;
            end else if (alu_ok) begin
                exp_src = wb_pkg::ALU;
            end else if (load_ok) begin
                exp_src = wb_pkg::LOAD;
            end
            // Pushes and outcome pulses that reach the queues at this edge
            if (smp_prev.mispredict) begin
                alu_occ      = alu_occ - alu_spec_occ;   // Window dropped
                alu_spec_occ = 0;
            end else if (smp_prev.correct) begin
                alu_spec_occ = 0;
            end
            if (smp_prev.alu && !(smp_prev.spec && smp_prev.mispredict)) begin
                alu_occ++;
                if (smp_prev.spec && !smp_prev.correct) begin
                    alu_spec_occ++;
                end
            end
            if (smp_prev.load) begin
                load_occ++;
            end
            case (exp_src)
                wb_pkg::JUMP: begin
                    exp_val = jump_exp.pop_front();
                    void'(jump_at.pop_front());
                    n_jump++;
                end
                wb_pkg::ALU: begin
                    exp_val = alu_exp.pop_front();
                    void'(alu_elig.pop_front());
                    void'(alu_mark.pop_front());
                    n_alu++;
                    alu_occ--;
                end
                wb_pkg::LOAD: begin
                    exp_val = load_exp.pop_front();
                    void'(load_elig.pop_front());
                    n_load++;
                    load_occ--;
                end
                default: ;
            endcase
            if (exp_src != wb_pkg::NONE) begin
                n_out++;
            end
            if (wb_src != exp_src || wb_out.valid != (exp_src != wb_pkg::NONE)) begin
                $display("MISMATCH at %0t: source %s valid %0b, expected %s",
                         $time, wb_src.name(), wb_out.valid, exp_src.name());
                errors++;
            end else if (wb_out.valid && (wb_out.reg_sel != exp_val.reg_sel ||
                                          wb_out.wdat != exp_val.wdat)) begin
                $display("MISMATCH at %0t: %s wrote r%0d=%h, expected r%0d=%h", $time,
                         wb_src.name(), wb_out.reg_sel, wb_out.wdat,
                         exp_val.reg_sel, exp_val.wdat);
                errors++;
            end
            // Ready while fewer than depth minus one entries are held
            if (alu_ready != (alu_occ < BUFFER_DEPTH - 1) ||
                load_ready != (load_occ < BUFFER_DEPTH - 1)) begin
                $display("MISMATCH at %0t: alu_ready %0b load_ready %0b with %0d/%0d queued",
                         $time, alu_ready, load_ready, alu_occ, load_occ);
                errors++;
            end
        end
    end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/10ps

module tb_top;

    localparam int buffer_depth = 4;   // Queue depth for DUT and model

    logic              CLK;
    logic              nRST;
    wb_pkg::wb_t       alu_in, load_in, jump_in;
    logic              branch_spec, branch_correct, branch_mispredict;
    wb_pkg::wb_t       wb_out;
    wb_pkg::wb_src_t   wb_src;
    logic              alu_ready, load_ready;
    logic              count_clr;
    int                errors, n_alu, n_load, n_jump;
    logic              busy;

    string             step_name[$];
    string             step_kind[$];
    int                step_val[$];     // Nine columns per step
    int                limit;           // Timeout in cycles, 0 until known
    int                cycles;
    logic [31:0]       rng;

    tb_clock #(.PERIOD(100), .RESET_CYCLES(8)) u_clock (.CLK(CLK), .nRST(nRST));

    writeback_top #(.BUFFER_DEPTH(buffer_depth)) dut (
        .CLK(CLK), .nRST(nRST),
        .alu_in(alu_in), .load_in(load_in), .jump_in(jump_in),
        .branch_spec(branch_spec), .branch_correct(branch_correct),
        .branch_mispredict(branch_mispredict),
        .wb_out(wb_out), .wb_src(wb_src),
        .alu_ready(alu_ready), .load_ready(load_ready)
    );

    tb_checker #(.BUFFER_DEPTH(buffer_depth)) u_checker (
        .CLK(CLK), .nRST(nRST),
        .alu_in(alu_in), .load_in(load_in), .jump_in(jump_in),
        .branch_spec(branch_spec), .branch_correct(branch_correct),
        .branch_mispredict(branch_mispredict),
        .wb_out(wb_out), .wb_src(wb_src),
        .alu_ready(alu_ready), .load_ready(load_ready), .count_clr(count_clr),
        .errors(errors), .n_alu(n_alu), .n_load(n_load), .n_jump(n_jump), .busy(busy)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // One result with a filler data word
    function automatic wb_pkg::wb_t make_result(input int v, input int sel, input logic [31:0] d);
        wb_pkg::wb_t r;
        r.valid   = (v != 0);
        r.reg_sel = wb_pkg::reg_sel_t'(sel);
        r.wdat    = (v != 0) ? d : '0;
        return r;
    endfunction

    task automatic drive_idle();
        alu_in            = '0;
        load_in           = '0;
        jump_in           = '0;
        branch_correct    = 1'b0;   // branch_spec keeps its level
        branch_mispredict = 1'b0;
        count_clr         = 1'b0;
    endtask

    // Next drive point, 10 ns after a rising edge
    task automatic next_cycle();
        @(posedge CLK);
        #10;
    endtask

    task automatic read_cases();
        int    fd;
        int    n;
        string line, nm, kd;
        int    v[9];
        fd = $fopen("tb/wb_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open tb/wb_cases.txt");
            $display("Checks failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") continue;
                n = $sscanf(line, "%s %s %d %d %d %d %d %d %d %d %d", nm, kd,
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                if (n != 11) continue;
                step_name.push_back(nm);
                step_kind.push_back(kd);
                for (int k = 0; k < 9; k++) begin
                    step_val.push_back(v[k]);
                end
            end
            $fclose(fd);
        end
    endtask

    // Cycle counter bounding the whole run
    always @(posedge CLK) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, the DUT stopped writing results", limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        int tests;
        int failed;
        int stalls;
        int err_before;
        int b;
        bit bad;
        limit  = 0;
        cycles = 0;
        rng    = 32'd84;
        tests  = 0;
        failed = 0;
        stalls = 0;
        branch_spec = 1'b0;
        drive_idle();
        read_cases();
        limit = step_name.size() * 4 + 100;
        @(posedge nRST);
        next_cycle();
        err_before = errors;
        for (int i = 0; i < step_name.size(); i++) begin
            b = i * 9;
            if (step_kind[i] == "drive") begin
                drive_idle();
                // Hold the step until every needed buffer has room
                while ((step_val[b] != 0 && !alu_ready) ||
                       (step_val[b+2] != 0 && !load_ready)) begin
                    stalls++;
                    next_cycle();
                end
                rng = xorshift32(rng);
                alu_in  = make_result(step_val[b], step_val[b+1], rng);
                rng = xorshift32(rng);
                load_in = make_result(step_val[b+2], step_val[b+3], rng);
                rng = xorshift32(rng);
                jump_in = make_result(step_val[b+4], step_val[b+5], rng);
                branch_spec       = step_val[b+6][0];
                branch_correct    = step_val[b+7][0];
                branch_mispredict = step_val[b+8][0];
                next_cycle();
            end else begin
                // End of test, columns hold expected ALU, load and jump writes
                drive_idle();
                branch_spec = 1'b0;
                while (busy) next_cycle();
                next_cycle();
                bad = (errors != err_before);
                if (n_alu != step_val[b] || n_load != step_val[b+1] ||
                    n_jump != step_val[b+2]) begin
                    $display("MISMATCH at %0t: %s wrote %0d/%0d/%0d, expected %0d/%0d/%0d",
                             $time, step_name[i], n_alu, n_load, n_jump,
                             step_val[b], step_val[b+1], step_val[b+2]);
                    bad = 1'b1;
                end
                tests++;
                if (bad) failed++;
                $display("test %s %s  alu %0d load %0d jump %0d stalls %0d", step_name[i],
                         bad ? "FAIL" : "ok", n_alu, n_load, n_jump, stalls);
                count_clr = 1'b1;   // Checker zeroes its per-test counts
                next_cycle();
                count_clr  = 1'b0;
                stalls     = 0;
                err_before = errors;
            end
        end
        $display("tests %0d, failed %0d, mismatches %0d", tests, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* tb/wb_cases.txt */
# name kind  alu_v alu_r load_v load_r jump_v jump_r spec correct mispredict
# kind end: the first three numbers are the expected ALU, load and jump write counts
jump     drive 0 0  0 0  1 3  0 0 0
jump     drive 0 0  0 0  1 4  0 0 0
jump     end   0 0 2 0 0 0 0 0 0
order    drive 1 1  0 0  0 0  0 0 0
order    drive 0 0  1 2  0 0  0 0 0
order    drive 1 3  0 0  0 0  0 0 0
order    drive 0 0  1 4  0 0  0 0 0
order    end   2 2 0 0 0 0 0 0 0
rr       drive 1 5  1 6  0 0  0 0 0
rr       drive 1 7  1 8  0 0  0 0 0
rr       drive 1 9  1 10 0 0  0 0 0
rr       end   3 3 0 0 0 0 0 0 0
commit   drive 1 11 0 0  0 0  0 0 0
commit   drive 1 12 0 0  0 0  1 0 0
commit   drive 1 13 1 14 0 0  1 0 0
commit   drive 0 0  0 0  0 0  1 1 0
commit   drive 1 15 0 0  0 0  0 0 0
commit   end   4 1 0 0 0 0 0 0 0
squash   drive 1 16 0 0  0 0  0 0 0
squash   drive 1 17 0 0  0 0  1 0 0
squash   drive 1 18 1 19 0 0  1 0 0
squash   drive 0 0  0 0  0 0  1 0 1
squash   drive 1 20 0 0  0 0  0 0 0
squash   end   2 1 0 0 0 0 0 0 0
mixed    drive 1 21 1 22 0 0  0 0 0
mixed    drive 0 0  0 0  1 23 0 0 0
mixed    drive 1 24 1 25 0 0  0 0 0
mixed    end   2 2 1 0 0 0 0 0 0
backpr   drive 1 26 1 27 0 0  0 0 0
backpr   drive 1 28 1 29 0 0  0 0 0
backpr   drive 1 30 1 31 0 0  0 0 0
backpr   drive 1 1  1 2  0 0  0 0 0
backpr   drive 1 3  1 4  0 0  0 0 0
backpr   drive 1 5  1 6  0 0  0 0 0
backpr   end   6 6 0 0 0 0 0 0 0

/* tb.f */
verilog/wb_pkg.sv
verilog/wb_intake.sv
verilog/wb_alu_queue.sv
verilog/wb_load_queue.sv
verilog/wb_arbiter.sv
verilog/writeback_top.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_top.sv

/* Bender.yml */
package:
  name: writeback

sources:
  - files:
      - verilog/wb_pkg.sv
      - verilog/wb_intake.sv
      - verilog/wb_alu_queue.sv
      - verilog/wb_load_queue.sv
      - verilog/wb_arbiter.sv
      - verilog/writeback_top.sv
  - target: simulation
    files:
      - tb/tb_clock.sv
      - tb/tb_checker.sv
      - tb/tb_top.sv
